// ==== src/axi_read_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_read_port import mem_stage_pkg::*; (
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire logic   rd_req,
    output logic        rd_ack,
    input  wire addr_t  rd_addr,
    input  wire logic   hazard,
    output axi_ar_t     ar,
    output logic        ar_valid,
    input  wire logic   ar_ready,
    input  wire axi_r_t r,
    input  wire logic   r_valid,
    output logic        r_ready,
    output word_t       rdata
);

    rd_state_t state;
    logic      beat_ok;

    assign ar_valid = (state == RD_ADDR);
    assign r_ready  = (state == RD_DATA);
    assign rd_ack   = (state == RD_DONE);

    assign beat_ok = r_valid && r.id == READ_ID;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= RD_IDLE;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (rd_req) begin
                        state <= hazard ? RD_HAZARD : RD_ADDR;
                    end
                end
                RD_HAZARD: begin
                    if (!hazard) begin
                        state <= RD_ADDR; // older store to this word has completed
                    end
                end
                RD_ADDR: begin
                    if (ar_ready) begin
                        state <= RD_DATA;
                    end
                end
                RD_DATA: begin
                    if (beat_ok) begin
                        state <= RD_DONE;
                    end
                end
                RD_DONE: begin
                    if (!rd_req) begin
                        state <= RD_IDLE;
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == RD_DATA && beat_ok) begin
            rdata <= r.data;
        end
    end

    always_comb begin
        ar.id   = READ_ID;
        ar.addr = {rd_addr[ADDR_W-1:2], 2'b00}; // whole word since wb picks the bytes
        ar.size = READ_SIZE;
    end

    a_no_ar_on_hazard: assert property (
        @(posedge clk) disable iff (rst)
        $rose(ar_valid) |-> !hazard
    );

endmodule

`default_nettype wire

// ==== src/axi_write_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_write_port import mem_stage_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     wr_req,
    output logic          wr_ack,
    input  wire ex_mem_t  instr,
    input  wire wr_slot_t slot,
    input  wire logic     full,
    output logic          alloc,
    output axi_aw_t       aw,
    output logic          aw_valid,
    input  wire logic     aw_ready,
    output axi_w_t        w,
    output logic          w_valid,
    input  wire logic     w_ready
);

    wr_state_t state;
    wr_slot_t  wr_id;
    logic      aw_left;
    logic      w_left;

    assign alloc  = ((state == WR_IDLE && wr_req) || state == WR_WAIT_SLOT) && !full;
    assign wr_ack = (state == WR_DONE);

    assign aw_left = aw_valid && !aw_ready; // still waiting for acceptance
    assign w_left  = w_valid && !w_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= WR_IDLE;
            aw_valid <= 1'b0;
            w_valid  <= 1'b0;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (wr_req) begin
                        state <= full ? WR_WAIT_SLOT : WR_SEND;
                    end
                end
                WR_WAIT_SLOT: begin
                    if (!full) begin
                        state <= WR_SEND;
                    end
                end
                WR_SEND: begin
                    if (!aw_left && !w_left) begin
                        state <= WR_DONE; // both channels taken
                    end
                end
                WR_DONE: begin
                    if (!wr_req) begin
                        state <= WR_IDLE;
                    end
                end
                default: state <= WR_IDLE;
            endcase

            if (alloc) begin
                aw_valid <= 1'b1;
                w_valid  <= 1'b1;
            end else begin
                aw_valid <= aw_left;
                w_valid  <= w_left;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            wr_id <= slot;
        end
    end

    // the stage holds instr steady while wr_req is up
    always_comb begin
        aw.id   = axi_id_t'(wr_id);
        aw.addr = {instr.alu_result[ADDR_W-1:2], instr.byte_offset};
        aw.size = instr.store_size;
        w.id    = axi_id_t'(wr_id);
        w.data  = instr.mem_wdata;
        w.strb  = instr.mem_write;
    end

    a_aw_stable: assert property (
        @(posedge clk) disable iff (rst)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw)
    );

    a_w_stable: assert property (
        @(posedge clk) disable iff (rst)
        w_valid && !w_ready |=> w_valid && $stable(w)
    );

endmodule

`default_nettype wire

// ==== src/mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_stage import mem_stage_pkg::*; (
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire ex_mem_t ex_bus,
    input  wire logic    ex_valid,
    output logic         mem_allowin,
    output mem_wb_t      wb_bus,
    output logic         wb_valid,
    input  wire logic    wb_allowin,
    output axi_ar_t      ar,
    output logic         ar_valid,
    input  wire logic    ar_ready,
    output axi_aw_t      aw,
    output logic         aw_valid,
    input  wire logic    aw_ready,
    output axi_w_t       w,
    output logic         w_valid,
    input  wire logic    w_ready,
    input  wire axi_r_t  r,
    input  wire logic    r_valid,
    output logic         r_ready,
    input  wire axi_b_t  b,
    input  wire logic    b_valid
);

    ex_mem_t  item;
    logic     stage_valid;
    logic     is_store;
    logic     is_load;
    logic     ready;
    logic     wb_fire;
    logic     rd_req;
    logic     rd_ack;
    logic     wr_req;
    logic     wr_ack;
    logic     alloc;
    logic     full;
    logic     hazard;
    wr_slot_t free_slot;
    word_t    rdata;

    assign is_store = |item.mem_write;
    assign is_load  = item.mem_en && !is_store;

    always_comb begin
        if (is_store) begin
            ready = wr_req && wr_ack;
        end else if (is_load) begin
            ready = rd_req && rd_ack;
        end else begin
            ready = 1'b1; // no bus access so it passes straight on
        end
    end

    assign wb_valid    = stage_valid && ready;
    assign mem_allowin = !stage_valid || (ready && wb_allowin);
    assign wb_fire     = wb_valid && wb_allowin;

    always_ff @(posedge clk) begin
        if (rst) begin
            stage_valid <= 1'b0;
        end else if (mem_allowin) begin
            stage_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_allowin && ex_valid) begin
            item <= ex_bus;
        end
    end

    // req stays up until the item leaves so a stalled access is issued once
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_req <= 1'b0;
            wr_req <= 1'b0;
        end else if (wb_fire) begin
            rd_req <= 1'b0;
            wr_req <= 1'b0;
        end else begin
            if (stage_valid && is_load && !rd_ack) begin
                rd_req <= 1'b1;
            end
            if (stage_valid && is_store && !wr_ack) begin
                wr_req <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_bus <= '0;
        end else if (wb_fire) begin
            wb_bus.pc         <= item.pc;
            wb_bus.dest       <= item.dest;
            wb_bus.reg_write  <= item.reg_write;
            wb_bus.mem_to_reg <= item.mem_to_reg;
            wb_bus.load_kind  <= item.load_kind;
            wb_bus.alu_result <= item.alu_result;
            wb_bus.mem_rdata  <= is_load ? rdata : '0;
        end
    end

    write_tracker u_write_tracker (
        .clk        (clk),
        .rst        (rst),
        .alloc      (alloc),
        .alloc_addr (aw.addr),
        .free_slot  (free_slot),
        .full       (full),
        .b          (b),
        .b_valid    (b_valid),
        .rd_addr    (item.alu_result),
        .hazard     (hazard)
    );

    axi_write_port u_axi_write_port (
        .clk      (clk),
        .rst      (rst),
        .wr_req   (wr_req),
        .wr_ack   (wr_ack),
        .instr    (item),
        .slot     (free_slot),
        .full     (full),
        .alloc    (alloc),
        .aw       (aw),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .w        (w),
        .w_valid  (w_valid),
        .w_ready  (w_ready)
    );

    axi_read_port u_axi_read_port (
        .clk      (clk),
        .rst      (rst),
        .rd_req   (rd_req),
        .rd_ack   (rd_ack),
        .rd_addr  (item.alu_result),
        .hazard   (hazard),
        .ar       (ar),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .r        (r),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .rdata    (rdata)
    );

endmodule

`default_nettype wire

// ==== src/mem_stage_pkg.sv ====
`default_nettype none

package mem_stage_pkg;

    localparam int DATA_W     = 32;
    localparam int ADDR_W     = 32;
    localparam int ID_W       = 4;
    localparam int REG_ADDR_W = 5;
    localparam int WR_SLOTS   = 4;

    typedef logic [DATA_W-1:0]           word_t;
    typedef logic [ADDR_W-1:0]           addr_t;
    typedef logic [ID_W-1:0]             axi_id_t;
    typedef logic [DATA_W/8-1:0]         strb_t;
    typedef logic [2:0]                  axi_size_t;
    typedef logic [REG_ADDR_W-1:0]       reg_addr_t;
    typedef logic [$clog2(WR_SLOTS)-1:0] wr_slot_t;

    localparam axi_id_t   READ_ID   = axi_id_t'(1); // all loads share this id
    localparam axi_size_t READ_SIZE = 3'd2;         // full word

    typedef enum logic [2:0] {
        LD_NONE, LD_BYTE, LD_BYTE_U, LD_HALF, LD_HALF_U, LD_WORD
    } load_kind_t;

    typedef enum logic [2:0] {
        RD_IDLE, RD_HAZARD, RD_ADDR, RD_DATA, RD_DONE
    } rd_state_t;

    typedef enum logic [1:0] {
        WR_IDLE, WR_WAIT_SLOT, WR_SEND, WR_DONE
    } wr_state_t;

    typedef struct packed {
        addr_t      pc;
        reg_addr_t  dest;
        strb_t      reg_write;   // register-write byte mask
        logic       mem_to_reg;
        load_kind_t load_kind;
        logic       mem_en;
        strb_t      mem_write;   // store strobes that stay zero for loads
        word_t      alu_result;
        word_t      mem_wdata;
        axi_size_t  store_size;
        logic [1:0] byte_offset;
    } ex_mem_t;

    typedef struct packed {
        addr_t      pc;
        reg_addr_t  dest;
        strb_t      reg_write;
        logic       mem_to_reg;
        load_kind_t load_kind;
        word_t      alu_result;
        word_t      mem_rdata;
    } mem_wb_t;

    typedef struct packed {
        axi_id_t   id;
        addr_t     addr;
        axi_size_t size;
    } axi_ar_t;

    typedef struct packed {
        axi_id_t   id;
        addr_t     addr;
        axi_size_t size;
    } axi_aw_t;

    typedef struct packed {
        axi_id_t id;
        word_t   data;
        strb_t   strb;
    } axi_w_t;

    typedef struct packed {
        axi_id_t id;
        word_t   data;
    } axi_r_t;

    typedef struct packed {
        axi_id_t id;
    } axi_b_t;

endpackage

`default_nettype wire

// ==== src/write_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module write_tracker import mem_stage_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     alloc,
    input  wire addr_t    alloc_addr,
    output wr_slot_t      free_slot,
    output logic          full,
    input  wire axi_b_t   b,
    input  wire logic     b_valid,
    input  wire addr_t    rd_addr,
    output logic          hazard
);

    logic [WR_SLOTS-1:0] busy;
    addr_t               word_addr [WR_SLOTS];
    logic                release_ok;
    wr_slot_t            release_slot;
    addr_t               rd_word;

    assign full = &busy;

    // lowest free entry wins
    always_comb begin
        free_slot = '0;
        for (int i = WR_SLOTS - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                free_slot = wr_slot_t'(i);
            end
        end
    end

    // responses carrying an id outside the table are ignored
    assign release_ok   = b_valid && (b.id < axi_id_t'(WR_SLOTS));
    assign release_slot = wr_slot_t'(b.id);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
        end else begin
            if (release_ok) begin
                busy[release_slot] <= 1'b0;
            end
            if (alloc) begin
                busy[free_slot] <= 1'b1; // never the slot being released
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            word_addr[free_slot] <= {alloc_addr[ADDR_W-1:2], 2'b00};
        end
    end

    assign rd_word = {rd_addr[ADDR_W-1:2], 2'b00};

    always_comb begin
        hazard = 1'b0;
        for (int i = 0; i < WR_SLOTS; i++) begin
            if (busy[i] && word_addr[i] == rd_word) begin
                hazard = 1'b1;
            end
        end
    end

    // the write port must wait for a free entry before allocating
    a_no_alloc_when_full: assert property (
        @(posedge clk) disable iff (rst)
        alloc |-> !full
    );

endmodule

`default_nettype wire

// ==== testbench/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk; // 10 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// ==== testbench/tb_mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_stage import mem_stage_pkg::*; ();

    // 21 instructions at up to ~40 cycles each plus hold windows fit well inside this limit
    localparam int TIMEOUT_CYCLES = 4000;

    logic    clk;
    logic    rst;
    ex_mem_t ex_bus;
    logic    ex_valid;
    logic    mem_allowin;
    mem_wb_t wb_bus;
    logic    wb_valid;
    logic    wb_allowin;
    axi_ar_t ar;
    logic    ar_valid;
    logic    ar_ready;
    axi_aw_t aw;
    logic    aw_valid;
    logic    aw_ready;
    axi_w_t  w;
    logic    w_valid;
    logic    w_ready;
    axi_r_t  r;
    logic    r_valid;
    logic    r_ready;
    axi_b_t  b;
    logic    b_valid;

    int      seed = 32'h6c60;
    int      cycles = 0;
    int      value_errors = 0;
    int      other_errors = 0;
    logic    r_fire = 1'b0;
    axi_ar_t ar_log [$];
    axi_aw_t aw_log [$];
    axi_w_t  w_log [$];
    addr_t   read_q [$];

    tb_clock u_tb_clock (.clk(clk), .rst(rst));

    mem_stage u_mem_stage (
        .clk(clk), .rst(rst),
        .ex_bus(ex_bus), .ex_valid(ex_valid), .mem_allowin(mem_allowin),
        .wb_bus(wb_bus), .wb_valid(wb_valid), .wb_allowin(wb_allowin),
        .ar(ar), .ar_valid(ar_valid), .ar_ready(ar_ready),
        .aw(aw), .aw_valid(aw_valid), .aw_ready(aw_ready),
        .w(w), .w_valid(w_valid), .w_ready(w_ready),
        .r(r), .r_valid(r_valid), .r_ready(r_ready),
        .b(b), .b_valid(b_valid)
    );

    function automatic logic coin();
        int v;
        v = $random(seed);
        return v[0];
    endfunction

    // contents of the modelled memory
    function automatic word_t mem_word(input addr_t addr);
        return addr ^ {addr[15:0], addr[31:16]} ^ 32'h5a3c_96e1;
    endfunction

    // bus responder whose random readiness is decided at the falling edge
    always @(negedge clk) begin
        if (r_fire) begin
            r_valid = 1'b0;
            r_fire  = 1'b0;
        end
        ar_ready = coin();
        aw_ready = coin();
        w_ready  = coin();
        if (ar_valid && ar_ready) begin
            ar_log.push_back(ar);
            read_q.push_back(ar.addr);
        end
        if (aw_valid && aw_ready) aw_log.push_back(aw);
        if (w_valid && w_ready) w_log.push_back(w);
        if (!r_valid && read_q.size() > 0 && coin()) begin
            r.id    = READ_ID;
            r.data  = mem_word(read_q.pop_front());
            r_valid = 1'b1;
        end
        r_fire = r_valid && r_ready; // beat taken at the next rising edge
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the DUT stopped responding, run ended after %0d cycles", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic report_failure(input string what);
        other_errors++;
        $display("failure at %0t: %s", $time, what);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_id(input string name, input axi_id_t got, input axi_id_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_wb(input string name, input mem_wb_t got, input mem_wb_t exp,
                            input bit with_rdata);
        mem_wb_t g;
        mem_wb_t e;
        g = got;
        e = exp;
        if (!with_rdata) begin
            g.mem_rdata = '0;
            e.mem_rdata = '0;
        end
        if (g !== e) begin
            value_errors++;
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    function automatic ex_mem_t make_plain(input addr_t pc, input reg_addr_t dest,
                                           input word_t alu);
        ex_mem_t x;
        x            = '0;
        x.pc         = pc;
        x.dest       = dest;
        x.reg_write  = 4'hf;
        x.load_kind  = LD_NONE;
        x.alu_result = alu;
        x.mem_wdata  = alu ^ 32'h0000_ffff; // ignored by a plain instruction
        return x;
    endfunction

    function automatic ex_mem_t make_load(input addr_t pc, input reg_addr_t dest,
                                          input addr_t addr, input load_kind_t kind);
        ex_mem_t x;
        x             = '0;
        x.pc          = pc;
        x.dest        = dest;
        x.reg_write   = 4'hf;
        x.mem_to_reg  = 1'b1;
        x.load_kind   = kind;
        x.mem_en      = 1'b1;
        x.alu_result  = addr;
        x.byte_offset = addr[1:0];
        return x;
    endfunction

    function automatic ex_mem_t make_store(input addr_t pc, input addr_t addr, input word_t data,
                                           input strb_t strb, input axi_size_t size);
        ex_mem_t x;
        x             = '0;
        x.pc          = pc;
        x.load_kind   = LD_NONE;
        x.mem_en      = 1'b1;
        x.mem_write   = strb;
        x.alu_result  = addr;
        x.mem_wdata   = data;
        x.store_size  = size;
        x.byte_offset = addr[1:0];
        return x;
    endfunction

    function automatic mem_wb_t expect_wb(input ex_mem_t x, input word_t rdata);
        mem_wb_t e;
        e.pc         = x.pc;
        e.dest       = x.dest;
        e.reg_write  = x.reg_write;
        e.mem_to_reg = x.mem_to_reg;
        e.load_kind  = x.load_kind;
        e.alu_result = x.alu_result;
        e.mem_rdata  = rdata;
        return e;
    endfunction

    // called at a falling edge and returns at the falling edge after acceptance
    task automatic send_instr(input ex_mem_t x);
        ex_bus   = x;
        ex_valid = 1'b1;
        #1;
        while (!mem_allowin) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        ex_valid = 1'b0;
        ex_bus   = '0;
    endtask

    task automatic wait_wb(output mem_wb_t got);
        while (!(wb_valid && wb_allowin)) @(negedge clk);
        @(negedge clk);
        got = wb_bus;
    endtask

    task automatic send_b(input axi_id_t id);
        b.id    = id;
        b_valid = 1'b1;
        @(negedge clk);
        b_valid = 1'b0;
    endtask

    task automatic check_load(input ex_mem_t x, input mem_wb_t got, input int idx);
        addr_t word_addr;
        word_addr = x.alu_result & 32'hffff_fffc;
        if (ar_log.size() <= idx) begin
            report_failure("load completed without a read address beat");
        end else begin
            check_id("ar.id", ar_log[idx].id, READ_ID);
            check_addr("ar.addr", ar_log[idx].addr, word_addr);
            check_word("ar.size", word_t'(ar_log[idx].size), word_t'(READ_SIZE));
        end
        check_wb("wb_bus load", got, expect_wb(x, mem_word(word_addr)), 1'b1);
    endtask

    task automatic check_store(input ex_mem_t x, input int idx, input axi_id_t exp_id);
        if (aw_log.size() <= idx || w_log.size() <= idx) begin
            report_failure("store released the stage before its aw and w beats");
        end else begin
            check_id("aw.id", aw_log[idx].id, exp_id);
            check_addr("aw.addr", aw_log[idx].addr, x.alu_result);
            check_word("aw.size", word_t'(aw_log[idx].size), word_t'(x.store_size));
            check_id("w.id", w_log[idx].id, exp_id);
            check_word("w.data", w_log[idx].data, x.mem_wdata);
            check_word("w.strb", word_t'(w_log[idx].strb), word_t'(x.mem_write));
        end
    endtask

    task automatic check_reset_state();
        if (ar_valid || aw_valid || w_valid || r_ready || wb_valid) begin
            report_failure("a valid or ready output is high right after reset");
        end
        check_wb("wb_bus after reset", wb_bus, '0, 1'b1);
    endtask

    task automatic test_plain();
        ex_mem_t x;
        mem_wb_t got;
        for (int i = 0; i < 4; i++) begin
            x = make_plain(32'h0040_0000 + 4 * i, reg_addr_t'(i + 3), word_t'($random(seed)));
            send_instr(x);
            wait_wb(got);
            check_wb("wb_bus plain", got, expect_wb(x, '0), 1'b0);
        end
        if (ar_log.size() != 0 || aw_log.size() != 0) begin
            report_failure("a plain instruction touched the data bus");
        end
    endtask

    task automatic test_load();
        ex_mem_t x;
        mem_wb_t got;
        ar_log.delete();
        for (int i = 0; i < 5; i++) begin
            x = make_load(32'h0040_0100 + 4 * i, reg_addr_t'(8 + i),
                          32'h0000_1000 + 8 * i + i % 4, load_kind_t'(i + 1));
            send_instr(x);
            wait_wb(got);
            check_load(x, got, i);
        end
    endtask

    task automatic test_store();
        ex_mem_t x;
        mem_wb_t got;
        aw_log.delete();
        w_log.delete();
        x = make_store(32'h0040_0200, 32'h0000_1806, 32'hcafe_0000, 4'b1100, 3'd1);
        send_instr(x);
        wait_wb(got); // no write response has been sent yet
        check_wb("wb_bus store", got, expect_wb(x, '0), 1'b0);
        check_store(x, 0, 4'd0);
        send_b(4'd0);
    endtask

    task automatic test_id_reuse();
        ex_mem_t x;
        mem_wb_t got;
        aw_log.delete();
        w_log.delete();
        for (int i = 0; i < 4; i++) begin
            x = make_store(32'h0040_0300 + 4 * i, 32'h0000_2000 + 16 * i,
                           word_t'($random(seed)), 4'hf, 3'd2);
            send_instr(x);
            wait_wb(got);
            check_store(x, i, axi_id_t'(i));
        end
        x = make_store(32'h0040_0310, 32'h0000_2100, 32'h1234_5678, 4'hf, 3'd2);
        send_instr(x);
        repeat (12) begin
            @(negedge clk);
            if (aw_valid) report_failure("fifth store raised aw_valid with every id busy");
            if (wb_valid) report_failure("fifth store left the stage with every id busy");
        end
        send_b(4'd2);
        wait_wb(got);
        check_store(x, 4, 4'd2);
        send_b(4'd0);
        send_b(4'd1);
        send_b(4'd3);
        send_b(4'd2);
    endtask

    task automatic test_load_hazard();
        ex_mem_t st;
        ex_mem_t ld;
        mem_wb_t got;
        ar_log.delete();
        st = make_store(32'h0040_0400, 32'h0000_3000, 32'h0bad_f00d, 4'hf, 3'd2);
        send_instr(st);
        wait_wb(got);
        ld = make_load(32'h0040_0404, 5'd12, 32'h0000_3002, LD_HALF);
        send_instr(ld);
        repeat (12) begin
            @(negedge clk);
            if (ar_valid) report_failure("load to a word with a pending store raised ar_valid");
        end
        send_b(4'd0);
        wait_wb(got);
        check_load(ld, got, 0);
        // pending store elsewhere does not block this load
        st = make_store(32'h0040_0408, 32'h0000_3100, 32'h0000_0055, 4'b0001, 3'd0);
        send_instr(st);
        wait_wb(got);
        ld = make_load(32'h0040_040c, 5'd13, 32'h0000_3204, LD_WORD);
        send_instr(ld);
        wait_wb(got);
        check_load(ld, got, 1);
        send_b(4'd0);
    endtask

    task automatic test_backpressure();
        ex_mem_t ld;
        ex_mem_t nxt;
        mem_wb_t prev;
        mem_wb_t got;
        ar_log.delete();
        wb_allowin = 1'b0;
        ld = make_load(32'h0040_0500, 5'd20, 32'h0000_5008, LD_BYTE_U);
        send_instr(ld);
        while (!wb_valid) @(negedge clk);
        prev = wb_bus;
        nxt  = make_plain(32'h0040_0504, 5'd21, 32'h7777_0001);
        ex_bus   = nxt;
        ex_valid = 1'b1;
        repeat (10) begin
            #1;
            if (mem_allowin) report_failure("mem_allowin high while write-back is stalled");
            if (!wb_valid) report_failure("wb_valid dropped while write-back is stalled");
            check_wb("wb_bus held", wb_bus, prev, 1'b1);
            @(negedge clk);
        end
        if (ar_log.size() != 1) report_failure("stalled load issued more than one read address");
        wb_allowin = 1'b1;
        @(negedge clk);
        ex_valid = 1'b0;
        ex_bus   = '0;
        check_load(ld, wb_bus, 0);
        wait_wb(got);
        check_wb("wb_bus after stall", got, expect_wb(nxt, '0), 1'b0);
        if (ar_log.size() != 1) report_failure("load re-issued its read after the stall");
    endtask

    initial begin
        ex_bus     = '0;
        ex_valid   = 1'b0;
        wb_allowin = 1'b1;
        ar_ready   = 1'b0;
        aw_ready   = 1'b0;
        w_ready    = 1'b0;
        r          = '0;
        r_valid    = 1'b0;
        b          = '0;
        b_valid    = 1'b0;
        wait (rst === 1'b1);
        wait (rst === 1'b0);
        @(negedge clk);
        check_reset_state();
        test_plain();
        test_load();
        test_store();
        test_id_reuse();
        test_load_hazard();
        test_backpressure();
        repeat (4) @(negedge clk);
        $display("summary: %0d value errors, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
src/mem_stage_pkg.sv
src/write_tracker.sv
src/axi_write_port.sv
src/axi_read_port.sv
src/mem_stage.sv
testbench/tb_clock.sv
testbench/tb_mem_stage.sv
